//--- rtl/rp_pkg.sv
////////////////////////////////////////////////////////////
// common widths, sample type and register map of the
// two-channel analog core, referenced as rp_pkg::name
////////////////////////////////////////////////////////////

package rp_pkg;

  ////////////////////////////////////////////////////////////
  // ADC samples
  ////////////////////////////////////////////////////////////

  localparam int ADC_RAW_W = 16;  // word on the ADC pins
  localparam int ADC_W     = 14;  // two reserved low bits dropped

  typedef logic signed [ADC_W-1:0] sample_t;  // two's complement sample

  // proportional feedback
  localparam int GAIN_W     = 16;  // signed gain
  localparam int GAIN_SHIFT = 8;   // so gain 256 is unity

  ////////////////////////////////////////////////////////////
  // register bus and map
  ////////////////////////////////////////////////////////////

  localparam int REG_AW = 4;
  localparam int REG_DW = 32;

  typedef enum logic [REG_AW-1:0] {
    CTRL   = 4'd0,  // bit 0 enables loopback
    OFS_A  = 4'd1,  // offset in low 14 bits
    OFS_B  = 4'd2,
    GAIN_A = 4'd3,  // gain in low 16 bits
    GAIN_B = 4'd4,
    LIM_A  = 4'd5,  // limit window
    LIM_B  = 4'd6
  } reg_addr_e;

  // hi sits in the upper half of the bus word
  typedef struct packed {
    logic [15:0] hi;  // sign-extended sample
    logic [15:0] lo;  // sign-extended sample
  } lim_pair_t;

  // one bus word, seen as plain value or as limit pair
  typedef union packed {
    logic [REG_DW-1:0] raw;
    lim_pair_t         lim;
  } reg_word_u;

  // reset window spans the whole 14-bit range
  localparam sample_t LIM_HI_RST = sample_t'(8191);
  localparam sample_t LIM_LO_RST = sample_t'(-8192);

endpackage

//--- rtl/rp_cfg_if.sv
////////////////////////////////////////////////////////////
// static configuration levels from the register block to
// the datapath; regs side drives, dp side only reads
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface rp_cfg_if #(
  parameter int N_CH = 2  // channel count
);

  logic                                loop_en;  // digital loopback
  rp_pkg::sample_t [N_CH-1:0]          ofs;      // static offset per channel
  logic [N_CH-1:0][rp_pkg::GAIN_W-1:0] gain;     // signed gain bits
  rp_pkg::sample_t [N_CH-1:0]          lim_hi;   // upper clamp
  rp_pkg::sample_t [N_CH-1:0]          lim_lo;   // lower clamp

  // register block side
  modport regs (
    output loop_en, ofs, gain, lim_hi, lim_lo
  );

  // datapath side
  modport dp (
    input  loop_en, ofs, gain, lim_hi, lim_lo
  );

endinterface

//--- rtl/rp_regs.sv
////////////////////////////////////////////////////////////
// configuration registers behind a valid/ready bus, with
// one read in flight; drives the config interface
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rp_regs (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  input  logic                      reg_valid_i,
  output logic                      reg_ready_o,
  input  logic                      reg_we_i,
  input  logic [rp_pkg::REG_AW-1:0] reg_addr_i,
  input  logic [rp_pkg::REG_DW-1:0] reg_wdata_i,
  output logic [rp_pkg::REG_DW-1:0] reg_rdata_o,
  output logic                      reg_rvalid_o,
  rp_cfg_if.regs                    cfg
);

  localparam int DW = rp_pkg::REG_DW;
  localparam int W  = rp_pkg::ADC_W;
  localparam int GW = rp_pkg::GAIN_W;

  rp_pkg::reg_word_u wr_word;  // incoming write data
  rp_pkg::reg_word_u rd_word;  // read mux output
  logic              wr_acc;
  logic              rd_acc;

  // sample to full bus word
  function automatic logic [DW-1:0] sext_word(input rp_pkg::sample_t s);
    return {{(DW-W){s[W-1]}}, s};
  endfunction

  // sample to half word of a limit pair
  function automatic logic [15:0] sext_half(input rp_pkg::sample_t s);
    return {{(16-W){s[W-1]}}, s};
  endfunction

  ////////////////////////////////////////////////////////////
  // handshake
  ////////////////////////////////////////////////////////////

  assign wr_word = reg_wdata_i;
  assign wr_acc  = reg_valid_i & reg_ready_o & reg_we_i;
  assign rd_acc  = reg_valid_i & reg_ready_o & ~reg_we_i;

  assign reg_ready_o = ~reg_rvalid_o;  // stall while read data is out

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      reg_rvalid_o <= 1'b0;
    else
      reg_rvalid_o <= rd_acc;  // exactly one cycle after accept
  end

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cfg.loop_en <= 1'b0;
      cfg.ofs     <= '0;
      cfg.gain    <= '0;  // no feedback out of reset
      cfg.lim_hi  <= {rp_pkg::LIM_HI_RST, rp_pkg::LIM_HI_RST};
      cfg.lim_lo  <= {rp_pkg::LIM_LO_RST, rp_pkg::LIM_LO_RST};
    end
    else if (wr_acc)
    begin
      case (reg_addr_i)
        rp_pkg::CTRL:   cfg.loop_en <= wr_word.raw[0];
        rp_pkg::OFS_A:  cfg.ofs[0]  <= wr_word.raw[W-1:0];
        rp_pkg::OFS_B:  cfg.ofs[1]  <= wr_word.raw[W-1:0];
        rp_pkg::GAIN_A: cfg.gain[0] <= wr_word.raw[GW-1:0];
        rp_pkg::GAIN_B: cfg.gain[1] <= wr_word.raw[GW-1:0];
        rp_pkg::LIM_A:
        begin
          cfg.lim_hi[0] <= wr_word.lim.hi[W-1:0];
          cfg.lim_lo[0] <= wr_word.lim.lo[W-1:0];
        end
        rp_pkg::LIM_B:
        begin
          cfg.lim_hi[1] <= wr_word.lim.hi[W-1:0];
          cfg.lim_lo[1] <= wr_word.lim.lo[W-1:0];
        end
        default: ;  // unmapped, write ignored
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read back
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    rd_word.raw = '0;  // unmapped reads as zero
    case (reg_addr_i)
      rp_pkg::CTRL:   rd_word.raw[0] = cfg.loop_en;
      rp_pkg::OFS_A:  rd_word.raw    = sext_word(cfg.ofs[0]);
      rp_pkg::OFS_B:  rd_word.raw    = sext_word(cfg.ofs[1]);
      rp_pkg::GAIN_A: rd_word.raw    = {{(DW-GW){cfg.gain[0][GW-1]}}, cfg.gain[0]};
      rp_pkg::GAIN_B: rd_word.raw    = {{(DW-GW){cfg.gain[1][GW-1]}}, cfg.gain[1]};
      rp_pkg::LIM_A:
      begin
        rd_word.lim.hi = sext_half(cfg.lim_hi[0]);
        rd_word.lim.lo = sext_half(cfg.lim_lo[0]);
      end
      rp_pkg::LIM_B:
      begin
        rd_word.lim.hi = sext_half(cfg.lim_hi[1]);
        rd_word.lim.lo = sext_half(cfg.lim_lo[1]);
      end
      default: ;
    endcase
  end

  always_ff @(posedge adc_clk)
  begin
    if (rd_acc)
      reg_rdata_o <= rd_word.raw;  // valid only with rvalid
  end

endmodule

//--- rtl/rp_adc_front.sv
////////////////////////////////////////////////////////////
// ADC input register per channel; turns the negative slope
// code into two's complement or takes the loopback value
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rp_adc_front #(
  parameter int N_CH = 2  // channel count
)(
  input  logic                                   adc_clk,
  input  logic                                   arst_n_i,
  input  logic [N_CH-1:0][rp_pkg::ADC_RAW_W-1:0] adc_raw_i,   // from pins
  input  rp_pkg::sample_t [N_CH-1:0]             loop_dat_i,  // limited dac value
  rp_cfg_if.dp                                   cfg,
  output rp_pkg::sample_t [N_CH-1:0]             adc_dat_o
);

  localparam int RW = rp_pkg::ADC_RAW_W;
  localparam int W  = rp_pkg::ADC_W;

  rp_pkg::sample_t [N_CH-1:0] adc_cnv;  // converted, ahead of the register

  ////////////////////////////////////////////////////////////
  // conversion
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < N_CH; i++)
  begin : g_cnv
    // top 14 bits only, low two are reserved
    // sign kept and magnitude bits inverted
    assign adc_cnv[i] = {adc_raw_i[i][RW-1], ~adc_raw_i[i][RW-2:RW-W]};
  end

  ////////////////////////////////////////////////////////////
  // input register with loopback select
  ////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      adc_dat_o <= '0;
    else if (cfg.loop_en)
      adc_dat_o <= loop_dat_i;  // digital loop replaces the ADC
    else
      adc_dat_o <= adc_cnv;
  end

endmodule

//--- rtl/rp_p_gain.sv
////////////////////////////////////////////////////////////
// proportional feedback term per channel; sample times
// signed gain, floor shift, saturate, one register stage
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rp_p_gain #(
  parameter int N_CH = 2  // channel count
)(
  input  logic                       adc_clk,
  input  logic                       arst_n_i,
  input  rp_pkg::sample_t [N_CH-1:0] adc_dat_i,  // from the front end
  rp_cfg_if.dp                       cfg,
  output rp_pkg::sample_t [N_CH-1:0] fb_dat_o    // feedback term
);

  localparam int W      = rp_pkg::ADC_W;
  localparam int PROD_W = rp_pkg::ADC_W + rp_pkg::GAIN_W;  // full product

  for (genvar i = 0; i < N_CH; i++)
  begin : g_ch
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] shifted;
    logic                     ovf;      // shifted value exceeds 14 bits
    rp_pkg::sample_t          fb_q;

    assign prod    = $signed(adc_dat_i[i]) * $signed(cfg.gain[i]);
    assign shifted = prod >>> rp_pkg::GAIN_SHIFT;  // rounds toward -inf

    // all bits above the sample sign must agree
    assign ovf = ~((&shifted[PROD_W-1:W-1]) | ~(|shifted[PROD_W-1:W-1]));

    always_ff @(posedge adc_clk or negedge arst_n_i)
    begin
      if (!arst_n_i)
        fb_q <= '0;
      else if (ovf)
        fb_q <= {shifted[PROD_W-1], {(W-1){~shifted[PROD_W-1]}}};  // rail
      else
        fb_q <= shifted[W-1:0];
    end

    assign fb_dat_o[i] = fb_q;
  end

endmodule

//--- rtl/rp_dac_out.sv
////////////////////////////////////////////////////////////
// DAC output stage per channel; offset plus feedback,
// saturation, window clamp with rail flags, then the
// unsigned negative slope output register
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rp_dac_out #(
  parameter int N_CH = 2  // channel count
)(
  input  logic                                adc_clk,
  input  logic                                arst_n_i,
  input  rp_pkg::sample_t [N_CH-1:0]          fb_dat_i,   // feedback term
  rp_cfg_if.dp                                cfg,
  output rp_pkg::sample_t [N_CH-1:0]          lim_dat_o,  // back to loopback
  output logic [N_CH-1:0][rp_pkg::ADC_W-1:0]  dac_dat_o,  // unsigned code
  output logic [N_CH-1:0][1:0]                railed_o    // {at hi, at lo}
);

  localparam int W = rp_pkg::ADC_W;

  for (genvar i = 0; i < N_CH; i++)
  begin : g_ch
    logic signed [W:0] sum;     // one guard bit
    rp_pkg::sample_t   sat;     // sum squeezed to 14 bits
    rp_pkg::sample_t   lim_q;
    logic [1:0]        rail_q;
    logic [W-1:0]      dac_q;

    ////////////////////////////////////////////////////////////
    // sum and saturation
    ////////////////////////////////////////////////////////////

    assign sum = $signed(cfg.ofs[i]) + $signed(fb_dat_i[i]);

    // top two bits differ on overflow
    assign sat = (sum[W] != sum[W-1]) ? {sum[W], {(W-1){~sum[W]}}}
                                      : sum[W-1:0];

    // window clamp, hi wins if the window is inverted
    always_ff @(posedge adc_clk or negedge arst_n_i)
    begin
      if (!arst_n_i)
      begin
        lim_q  <= '0;
        rail_q <= 2'b00;
      end
      else if (sat >= $signed(cfg.lim_hi[i]))
      begin
        lim_q  <= cfg.lim_hi[i];
        rail_q <= 2'b10;  // at high limit
      end
      else if (sat <= $signed(cfg.lim_lo[i]))
      begin
        lim_q  <= cfg.lim_lo[i];
        rail_q <= 2'b01;  // at low limit
      end
      else
      begin
        lim_q  <= sat;
        rail_q <= 2'b00;
      end
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge adc_clk or negedge arst_n_i)
    begin
      if (!arst_n_i)
        dac_q <= {1'b0, {(W-1){1'b1}}};  // midscale, code for zero
      else
        dac_q <= {lim_q[W-1], ~lim_q[W-2:0]};  // back to negative slope
    end

    assign lim_dat_o[i] = lim_q;
    assign railed_o[i]  = rail_q;
    assign dac_dat_o[i] = dac_q;
  end

endmodule

//--- rtl/rp_analog_top.sv
////////////////////////////////////////////////////////////
// two-channel analog signal path on adc_clk; register
// block beside front end, feedback gain and DAC stage
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rp_analog_top (
  input  logic                      adc_clk,
  input  logic                      arst_n_i,
  // ADC
  input  logic [15:0]               adc_dat_a_i,
  input  logic [15:0]               adc_dat_b_i,
  // register bus
  input  logic                      reg_valid_i,
  output logic                      reg_ready_o,
  input  logic                      reg_we_i,
  input  logic [rp_pkg::REG_AW-1:0] reg_addr_i,
  input  logic [rp_pkg::REG_DW-1:0] reg_wdata_i,
  output logic [rp_pkg::REG_DW-1:0] reg_rdata_o,
  output logic                      reg_rvalid_o,
  // DAC
  output logic [13:0]               dac_dat_a_o,   // unsigned negative slope
  output logic [13:0]               dac_dat_b_o,
  output logic [3:0]                dac_railed_o   // {b_hi, b_lo, a_hi, a_lo}
);

  localparam int N_CH = 2;  // register map covers two channels

  logic [N_CH-1:0][rp_pkg::ADC_RAW_W-1:0] adc_raw;
  rp_pkg::sample_t [N_CH-1:0]             adc_dat;  // front end out
  rp_pkg::sample_t [N_CH-1:0]             fb_dat;   // feedback term
  rp_pkg::sample_t [N_CH-1:0]             lim_dat;  // limited, for loopback
  logic [N_CH-1:0][rp_pkg::ADC_W-1:0]     dac_dat;
  logic [N_CH-1:0][1:0]                   railed;

  rp_cfg_if #(.N_CH(N_CH)) cfg_if ();

  // channel packing
  assign adc_raw      = {adc_dat_b_i, adc_dat_a_i};
  assign dac_dat_a_o  = dac_dat[0];
  assign dac_dat_b_o  = dac_dat[1];
  assign dac_railed_o = railed;

  rp_regs rp_regs_inst (
    .adc_clk      (adc_clk     ),
    .arst_n_i     (arst_n_i    ),
    .reg_valid_i  (reg_valid_i ),
    .reg_ready_o  (reg_ready_o ),
    .reg_we_i     (reg_we_i    ),
    .reg_addr_i   (reg_addr_i  ),
    .reg_wdata_i  (reg_wdata_i ),
    .reg_rdata_o  (reg_rdata_o ),
    .reg_rvalid_o (reg_rvalid_o),
    .cfg          (cfg_if.regs )
  );

  rp_adc_front #(.N_CH(N_CH)) rp_adc_front_inst (
    .adc_clk    (adc_clk  ),
    .arst_n_i   (arst_n_i ),
    .adc_raw_i  (adc_raw  ),
    .loop_dat_i (lim_dat  ),
    .cfg        (cfg_if.dp),
    .adc_dat_o  (adc_dat  )
  );

  rp_p_gain #(.N_CH(N_CH)) rp_p_gain_inst (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .adc_dat_i (adc_dat  ),
    .cfg       (cfg_if.dp),
    .fb_dat_o  (fb_dat   )
  );

  rp_dac_out #(.N_CH(N_CH)) rp_dac_out_inst (
    .adc_clk   (adc_clk  ),
    .arst_n_i  (arst_n_i ),
    .fb_dat_i  (fb_dat   ),
    .cfg       (cfg_if.dp),
    .lim_dat_o (lim_dat  ),
    .dac_dat_o (dac_dat  ),
    .railed_o  (railed   )
  );

endmodule

//--- test/tb_checker.sv
////////////////////////////////////////////////////////////
// watches DUT outputs on the falling edge and compares
// them with the expected values from the testbench top
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_checker (
  input  logic            adc_clk,
  input  logic [8*12-1:0] name_i,
  input  logic            cmp_i,        // compare DAC outputs now
  input  logic [13:0]     exp_a_i,      // expected limited samples
  input  logic [13:0]     exp_b_i,
  input  logic [3:0]      exp_rail_i,
  input  logic            rd_cmp_i,     // read data due now
  input  logic [31:0]     exp_rdata_i,
  input  logic            lat_start_i,  // new ADC word applied
  input  logic [13:0]     dac_a_i,
  input  logic [13:0]     dac_b_i,
  input  logic [3:0]      railed_i,
  input  logic            ready_i,
  input  logic            rvalid_i,
  input  logic [31:0]     rdata_i,
  output int              err_dac_o,
  output int              err_rd_o,
  output int              err_lat_o
);

  int   lat_cnt;
  logic lat_run;

  // sample to unsigned negative slope code
  function automatic logic [13:0] to_code(input logic [13:0] s);
    return {s[13], ~s[12:0]};
  endfunction

  initial
  begin
    err_dac_o = 0;
    err_rd_o  = 0;
    err_lat_o = 0;
    lat_run   = 1'b0;
    lat_cnt   = 0;
  end

  always @(negedge adc_clk)
  begin
    if (cmp_i)
    begin
      if (dac_a_i !== to_code(exp_a_i))
      begin
        $display("ERR %s dac_a expected %h actual %h", name_i, to_code(exp_a_i), dac_a_i);
        err_dac_o++;
      end
      if (dac_b_i !== to_code(exp_b_i))
      begin
        $display("ERR %s dac_b expected %h actual %h", name_i, to_code(exp_b_i), dac_b_i);
        err_dac_o++;
      end
      if (railed_i !== exp_rail_i)
      begin
        $display("ERR %s railed expected %b actual %b", name_i, exp_rail_i, railed_i);
        err_dac_o++;
      end
    end
    if (rd_cmp_i)
    begin
      if (!rvalid_i || ready_i)  // one cycle after accept, stalled
      begin
        $display("%s: read data not valid or bus not stalled in the cycle after accept",
                 name_i);
        err_rd_o++;
      end
      else if (rdata_i !== exp_rdata_i)
      begin
        $display("ERR %s rdata expected %h actual %h", name_i, exp_rdata_i, rdata_i);
        err_rd_o++;
      end
    end
    if (lat_start_i)
    begin
      lat_cnt = 0;
      lat_run = 1'b1;
    end
    else if (lat_run)
    begin
      lat_cnt++;
      if (dac_a_i === to_code(exp_a_i))
      begin
        lat_run = 1'b0;
        if (lat_cnt != 4)  // edges from the applied word to the DAC code
        begin
          $display("ERR %s cycles expected 4 actual %0d", name_i, lat_cnt);
          err_lat_o++;
        end
      end
      else if (lat_cnt > 8)  // gives up while the top is still waiting
      begin
        $display("%s: DAC output never reached the expected code", name_i);
        err_lat_o++;
        lat_run = 1'b0;
      end
    end
  end

endmodule

//--- test/tb_properties.sv
////////////////////////////////////////////////////////////
// register bus handshake and reset state assertions,
// bound into every rp_regs instance
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_properties (
  input logic adc_clk,
  input logic arst_n_i,
  input logic reg_valid_i,
  input logic reg_we_i,
  input logic reg_ready_o,
  input logic reg_rvalid_o
);

  logic rd_acc;

  assign rd_acc = reg_valid_i & reg_ready_o & ~reg_we_i;

  // read data lasts one cycle, then the bus is free again
  a_rvalid_single: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    reg_rvalid_o |=> (reg_ready_o && !reg_rvalid_o))
    else $error("rvalid held longer than one cycle or ready not back");

  // data out and bus stalled in the cycle after accept
  a_rvalid_follows: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    rd_acc |=> (reg_rvalid_o && !reg_ready_o))
    else $error("rvalid missing or ready high after an accepted read");

  a_reset_state: assert property (@(posedge adc_clk)
    !arst_n_i |-> (reg_ready_o && !reg_rvalid_o))
    else $error("bus outputs not in reset state");

endmodule

bind rp_regs tb_properties tb_properties_inst (.*);

//--- test/tb_top.sv
////////////////////////////////////////////////////////////
// testbench top for the analog core; register bus tasks,
// stimulus table applied in a loop, closing summary
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_top;

  typedef struct packed {
    logic [8*12-1:0] name;
    logic            loop;
    logic [13:0]     ofs_a, ofs_b, hi, lo, exp_a, exp_b;
    logic [15:0]     gain, adc_a, adc_b;
    logic [7:0]      settle;    // cycles before compare
    logic [3:0]      exp_rail;  // {b_hi, b_lo, a_hi, a_lo}
  } row_t;

  localparam int N_ROWS = 10;
  localparam int TMO    = 50;  // cycles per handshake wait

  logic adc_clk = 1'b0, arst_n = 1'b0;
  logic [15:0] adc_a = '0, adc_b = '0;
  logic reg_valid = 1'b0, reg_we = 1'b0, reg_ready, reg_rvalid;
  logic [3:0] reg_addr = '0;
  logic [31:0] reg_wdata = '0, reg_rdata, exp_rdata = '0;
  logic [13:0] dac_a, dac_b, exp_a = '0, exp_b = '0;
  logic [3:0] railed, exp_rail = '0;
  logic [8*12-1:0] name = '0;
  logic cmp = 1'b0, rd_cmp = 1'b0, lat_start = 1'b0;
  int err_dac, err_rd, err_lat;
  logic [31:0] lcg_state = 32'h1b80;
  row_t rows [N_ROWS];

  always #50 adc_clk = ~adc_clk;  // 100 ns period

  rp_analog_top rp_analog_top_inst (
    .adc_clk(adc_clk), .arst_n_i(arst_n), .adc_dat_a_i(adc_a), .adc_dat_b_i(adc_b),
    .reg_valid_i(reg_valid), .reg_ready_o(reg_ready), .reg_we_i(reg_we),
    .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata),
    .reg_rvalid_o(reg_rvalid), .dac_dat_a_o(dac_a), .dac_dat_b_o(dac_b),
    .dac_railed_o(railed)
  );

  tb_checker tb_checker_inst (
    .adc_clk(adc_clk), .name_i(name), .cmp_i(cmp), .exp_a_i(exp_a), .exp_b_i(exp_b),
    .exp_rail_i(exp_rail), .rd_cmp_i(rd_cmp), .exp_rdata_i(exp_rdata),
    .lat_start_i(lat_start), .dac_a_i(dac_a), .dac_b_i(dac_b), .railed_i(railed),
    .ready_i(reg_ready), .rvalid_i(reg_rvalid), .rdata_i(reg_rdata),
    .err_dac_o(err_dac), .err_rd_o(err_rd), .err_lat_o(err_lat)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int clip14(input int v);
    return (v > 8191) ? 8191 : ((v < -8192) ? -8192 : v);
  endfunction

  // expected {rail, value} from the datapath rules
  function automatic logic [15:0] predict(input logic [13:0] ofs, input logic [15:0] gain,
                                          input logic [13:0] hi, lo, input logic [15:0] raw);
    logic [13:0] s14;
    int v;
    s14 = {raw[15], ~raw[14:2]};  // negative slope to two's complement
    v = $signed(s14) * $signed(gain);
    v = clip14(v >>> 8);           // floor shift, then saturate
    v = clip14($signed(ofs) + v);
    if (v >= $signed(hi))
      return {2'b10, hi};
    else if (v <= $signed(lo))
      return {2'b01, lo};
    return {2'b00, v[13:0]};
  endfunction

  function automatic row_t make_row(input logic [8*12-1:0] nm, input logic lp,
                                    input logic [13:0] oa, ob, input logic [15:0] g,
                                    input logic [13:0] hi, lo, input logic [15:0] aa, ab,
                                    input logic [7:0] st);
    row_t r;
    logic [15:0] pa, pb;
    pa = predict(oa, g, hi, lo, aa);
    pb = predict(ob, g, hi, lo, ab);
    r = '{nm, lp, oa, ob, hi, lo, pa[13:0], pb[13:0], g, aa, ab, st, {pb[15:14], pa[15:14]}};
    return r;
  endfunction

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $finish;
  endtask

  task automatic step();
    @(posedge adc_clk);
    #10;  // drive after the edge
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (!reg_ready)
    begin
      step();
      n++;
      if (n > TMO)
        abort("timeout: register bus never became ready");
    end
  endtask

  task automatic bus_write(input logic [3:0] a, input logic [31:0] d);
    reg_valid = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    wait_ready();
    step();  // accepted on this edge
    reg_valid = 1'b0;
    reg_we    = 1'b0;
  endtask

  task automatic bus_read(input logic [8*12-1:0] nm, input logic [3:0] a,
                          input logic [31:0] exp);
    reg_valid = 1'b1;
    reg_addr  = a;
    wait_ready();
    step();
    reg_valid = 1'b0;
    name      = nm;
    exp_rdata = exp;
    rd_cmp    = 1'b1;  // checker looks at rvalid, ready and data now
    step();
    rd_cmp    = 1'b0;
  endtask

  task automatic apply_row(input row_t r);
    adc_a = r.adc_a;
    adc_b = r.adc_b;
    bus_write(4'd1, {{18{r.ofs_a[13]}}, r.ofs_a});
    bus_write(4'd2, {{18{r.ofs_b[13]}}, r.ofs_b});
    bus_write(4'd3, {{16{r.gain[15]}}, r.gain});
    bus_write(4'd4, {{16{r.gain[15]}}, r.gain});
    bus_write(4'd5, {{2{r.hi[13]}}, r.hi, {2{r.lo[13]}}, r.lo});
    bus_write(4'd6, {{2{r.hi[13]}}, r.hi, {2{r.lo[13]}}, r.lo});
    bus_write(4'd0, {31'b0, r.loop});  // loopback last
    repeat (r.settle) step();
    name     = r.name;
    exp_a    = r.exp_a;
    exp_b    = r.exp_b;
    exp_rail = r.exp_rail;
    cmp = 1'b1;
    step();
    cmp = 1'b0;
  endtask

  initial
  begin
    #2_000_000;  // global watchdog
    abort("timeout: simulation ran past its time limit");
  end

  initial
  begin
    logic [15:0] p;
    repeat (4) @(posedge adc_clk);
    #10 arst_n = 1'b1;
    name = "reset";  // zero in, midscale out
    cmp  = 1'b1;
    step();
    cmp = 1'b0;

    ////////////////////////////////////////////////////////////
    // register read-back
    ////////////////////////////////////////////////////////////
    bus_read("rst_ctrl", 4'd0, 32'h0);
    bus_read("rst_ofs_a", 4'd1, 32'h0);
    bus_read("rst_ofs_b", 4'd2, 32'h0);
    bus_read("rst_gain_a", 4'd3, 32'h0);
    bus_read("rst_gain_b", 4'd4, 32'h0);
    bus_read("rst_lim_a", 4'd5, 32'h1FFF_E000);
    bus_read("rst_lim_b", 4'd6, 32'h1FFF_E000);  // +8191 / -8192
    bus_write(4'd1, 32'h0000_1ABC);
    bus_write(4'd2, 32'h0000_2005);
    bus_write(4'd3, 32'h0000_8001);
    bus_write(4'd4, 32'h0000_7F00);
    bus_write(4'd5, 32'h0BB8_F448);
    bus_write(4'd6, 32'h03E8_FC18);  // +1000 / -1000
    bus_write(4'd0, 32'h1);
    bus_write(4'd7, 32'hFFFF_FFFF);  // unmapped
    bus_read("rd_ofs_a", 4'd1, 32'h0000_1ABC);
    bus_read("rd_ofs_b", 4'd2, 32'hFFFF_E005);  // sign extended
    bus_read("rd_gain_a", 4'd3, 32'hFFFF_8001);
    bus_read("rd_gain_b", 4'd4, 32'h0000_7F00);
    bus_read("rd_lim_a", 4'd5, 32'h0BB8_F448);
    bus_read("rd_lim_b", 4'd6, 32'h03E8_FC18);
    bus_read("rd_ctrl", 4'd0, 32'h1);
    bus_read("rd_unmapped", 4'd7, 32'h0);
    bus_write(4'd0, 32'h0);

    ////////////////////////////////////////////////////////////
    // datapath table
    ////////////////////////////////////////////////////////////
    rows[0] = make_row("ofs_rand0", 0, lcg_next() >> 18, lcg_next() >> 18, 16'd0,
                       14'h1FFF, 14'h2000, lcg_next() >> 16, lcg_next() >> 16, 6);
    rows[1] = make_row("ofs_rand1", 0, lcg_next() >> 18, lcg_next() >> 18, 16'd0,
                       14'h1FFF, 14'h2000, lcg_next() >> 16, lcg_next() >> 16, 6);
    rows[2] = make_row("gain_unity", 0, 14'd0, 14'd0, 16'd256,
                       14'h1FFF, 14'h2000, lcg_next() >> 16, lcg_next() >> 16, 6);
    rows[3] = make_row("gain_ofs", 0, 14'd50, -14'sd50, 16'd256,
                       14'h1FFF, 14'h2000, 16'h1234, 16'hC000, 6);
    rows[4] = make_row("gain_half", 0, 14'd3, 14'd0, 16'd128,
                       14'h1FFF, 14'h2000, 16'hC004, 16'h9FFC, 6);
    rows[5] = make_row("sat_full", 0, 14'd4000, -14'sd4000, 16'h7FFF,
                       14'h1FFF, 14'h2000, 16'h0000, 16'hFFFF, 6);
    rows[6] = make_row("lim_window", 0, 14'd4000, -14'sd4000, 16'h7FFF,
                       14'd3000, -14'sd3000, 16'h0000, 16'hFFFF, 6);
    rows[7] = make_row("loop_k", 1, 14'd777, -14'sd333, 16'd0,
                       14'h1FFF, 14'h2000, 16'h0000, 16'hFFFF, 12);
    rows[7].exp_a = 14'd777;   // loop holds the offset
    rows[7].exp_b = -14'sd333;
    rows[7].exp_rail = 4'b0000;
    rows[8] = make_row("loop_ramp", 1, 14'd100, -14'sd100, 16'd256,
                       14'd1000, -14'sd1000, 16'h5555, 16'hAAAA, 40);
    rows[8].exp_a = 14'd1000;  // ramps into the window edges
    rows[8].exp_b = -14'sd1000;
    rows[8].exp_rail = 4'b0110;
    rows[9] = make_row("loop_off", 0, 14'd0, 14'd0, 16'd256,
                       14'h1FFF, 14'h2000, 16'h8000, 16'h8000, 8);
    for (int i = 0; i < N_ROWS; i++)
      apply_row(rows[i]);

    // latency, config of the last row still active
    p = predict(14'd0, 16'd256, 14'h1FFF, 14'h2000, 16'h4000);
    adc_a     = 16'h4000;
    name      = "latency";
    exp_a     = p[13:0];
    lat_start = 1'b1;
    step();
    lat_start = 1'b0;
    repeat (10) step();

    $display("errors: dac %0d, readback %0d, latency %0d", err_dac, err_rd, err_lat);
    if (err_dac + err_rd + err_lat == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- src.f
rtl/rp_pkg.sv
rtl/rp_cfg_if.sv
rtl/rp_regs.sv
rtl/rp_adc_front.sv
rtl/rp_p_gain.sv
rtl/rp_dac_out.sv
rtl/rp_analog_top.sv
test/tb_checker.sv
test/tb_properties.sv
test/tb_top.sv

//--- Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tb_top
FILELIST := src.f
OBJDIR   := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
